//--- project.f
hdl/mips_pkg.sv
hdl/control_unit.sv
hdl/alu_control.sv
hdl/alu.sv
hdl/register_file.sv
hdl/instr_memory.sv
hdl/data_memory.sv
hdl/mips_core.sv
verification/clock_gen.sv
verification/result_checker.sv
verification/tb_mips_core.sv

//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_mips_core -f project.f > build.log 2>&1 \
	|| { cat build.log; echo "Verilator build failed"; exit 1; }

./obj_dir/Vtb_mips_core > sim.log 2>&1 ; cat sim.log

grep -qx "TEST RESULT: PASS" sim.log \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

//--- verification/tb_mips_core.sv
module tb_mips_core;

	localparam int PC_W       = 8;
	localparam int DMEM_AW    = 8;
	localparam int PROG_LEN   = 46;
	localparam int CLK_PERIOD = 4;
	localparam int FINAL_PC   = 40;	// J to itself
	localparam int SETTLE     = 4;	// Cycles to catch stray writes
	localparam int WATCHDOG_T = (PROG_LEN + 20) * CLK_PERIOD;

	logic                 clk;
	logic                 rst_n;
	logic                 run;
	logic                 imem_we;
	logic [PC_W-1:0]      imem_addr;
	logic [31:0]          imem_wdata;
	logic [PC_W-1:0]      pc;
	mips_pkg::wb_event_t  reg_wb;
	mips_pkg::mem_event_t mem_wr;
	int                   err_count;
	int                   seen_count;
	int                   exp_count;
	logic                 all_seen;
	logic [31:0]          prog [PROG_LEN];	// Program table

	clock_gen #(.HALF_PERIOD(CLK_PERIOD / 2), .RESET_CYCLES(8)) u_clk (
		.clk   (clk),
		.rst_n (rst_n)
	);

	mips_core #(.PC_W(PC_W), .DMEM_AW(DMEM_AW)) u_dut (
		.clk        (clk),
		.rst_n      (rst_n),
		.run        (run),
		.imem_we    (imem_we),
		.imem_addr  (imem_addr),
		.imem_wdata (imem_wdata),
		.pc         (pc),
		.reg_wb     (reg_wb),
		.mem_wr     (mem_wr)
	);

	result_checker #(.PC_W(PC_W), .FINAL_PC(FINAL_PC)) u_check (
		.clk        (clk),
		.rst_n      (rst_n),
		.pc         (pc),
		.reg_wb     (reg_wb),
		.mem_wr     (mem_wr),
		.err_count  (err_count),
		.seen_count (seen_count),
		.exp_count  (exp_count),
		.all_seen   (all_seen)
	);

	function automatic logic [31:0] enc_r(input logic [4:0] rs, input logic [4:0] rt,
		input logic [4:0] rd, input logic [5:0] funct);
		return {6'b000000, rs, rt, rd, 5'b00000, funct};
	endfunction

	function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] enc_j(input logic [5:0] op, input logic [25:0] target);
		return {op, target};
	endfunction

	task automatic build_program;
		for (int i = 0; i < PROG_LEN; i++)
			prog[i] = 32'h0;	// SLL r0 form, a no-op
		prog[0]  = enc_i(mips_pkg::OP_ADDI, 5'd0, 5'd1, 16'd12);
		prog[1]  = enc_i(mips_pkg::OP_ADDI, 5'd0, 5'd2, 16'hFFFB);	// -5
		prog[2]  = enc_r(5'd1, 5'd2, 5'd3, mips_pkg::F_ADD);
		prog[3]  = enc_r(5'd1, 5'd2, 5'd4, mips_pkg::F_SUB);
		prog[4]  = enc_r(5'd1, 5'd2, 5'd5, mips_pkg::F_AND);
		prog[5]  = enc_r(5'd1, 5'd2, 5'd6, mips_pkg::F_OR);
		prog[6]  = enc_r(5'd1, 5'd2, 5'd7, mips_pkg::F_XOR);
		prog[7]  = enc_r(5'd2, 5'd1, 5'd8, mips_pkg::F_SLT);
		prog[8]  = enc_r(5'd1, 5'd2, 5'd9, mips_pkg::F_SLT);
		prog[9]  = enc_i(mips_pkg::OP_LUI, 5'd0, 5'd10, 16'h1234);
		prog[10] = enc_i(mips_pkg::OP_ORI, 5'd10, 5'd10, 16'h8001);
		prog[11] = enc_i(mips_pkg::OP_ANDI, 5'd2, 5'd11, 16'h80F0);
		prog[12] = enc_i(mips_pkg::OP_XORI, 5'd2, 5'd12, 16'hFFFF);
		prog[13] = enc_i(mips_pkg::OP_SW, 5'd1, 5'd10, 16'd3);	// mem[15]
		prog[14] = enc_i(mips_pkg::OP_LW, 5'd0, 5'd13, 16'd15);
		prog[15] = enc_i(mips_pkg::OP_ADDI, 5'd1, 5'd0, 16'd7);	// Dest r0, no event
		prog[16] = enc_r(5'd0, 5'd1, 5'd14, mips_pkg::F_ADD);
		prog[17] = enc_i(mips_pkg::OP_BEQ, 5'd1, 5'd14, 16'd1);	// Taken
		prog[18] = enc_i(mips_pkg::OP_ADDI, 5'd0, 5'd15, 16'd1);	// Skipped
		prog[19] = enc_i(mips_pkg::OP_BNE, 5'd1, 5'd14, 16'd1);	// Not taken
		prog[20] = enc_i(mips_pkg::OP_ADDI, 5'd0, 5'd15, 16'd2);
		prog[21] = enc_i(mips_pkg::OP_BNE, 5'd1, 5'd2, 16'd1);	// Taken
		prog[22] = enc_i(mips_pkg::OP_ADDI, 5'd0, 5'd16, 16'd3);	// Skipped
		prog[23] = enc_i(mips_pkg::OP_BEQ, 5'd1, 5'd2, 16'd1);	// Not taken
		prog[24] = enc_i(mips_pkg::OP_ADDI, 5'd0, 5'd16, 16'd4);
		prog[25] = enc_i(mips_pkg::OP_REGIMM, 5'd2, mips_pkg::RT_BGEZ, 16'd1);	// rs < 0
		prog[26] = enc_i(mips_pkg::OP_ADDI, 5'd0, 5'd17, 16'd5);
		prog[27] = enc_i(mips_pkg::OP_REGIMM, 5'd1, mips_pkg::RT_BGEZ, 16'd1);	// Taken
		prog[28] = enc_i(mips_pkg::OP_ADDI, 5'd0, 5'd17, 16'd6);	// Skipped
		prog[29] = enc_i(mips_pkg::OP_REGIMM, 5'd1, mips_pkg::RT_BGEZAL, 16'd1);
		prog[30] = enc_i(mips_pkg::OP_ADDI, 5'd0, 5'd19, 16'd6);	// Skipped
		prog[31] = enc_i(mips_pkg::OP_REGIMM, 5'd2, mips_pkg::RT_BGEZAL, 16'd1);
		prog[32] = enc_i(mips_pkg::OP_ADDI, 5'd0, 5'd18, 16'd7);
		prog[33] = enc_j(mips_pkg::OP_J, 26'd35);
		prog[34] = enc_i(mips_pkg::OP_ADDI, 5'd0, 5'd19, 16'd8);	// Skipped
		prog[35] = enc_j(mips_pkg::OP_JAL, 26'd42);
		prog[36] = enc_i(mips_pkg::OP_ADDI, 5'd0, 5'd20, 16'd9);
		prog[37] = enc_i(mips_pkg::OP_ADDI, 5'd0, 5'd21, 16'd44);
		prog[38] = enc_r(5'd21, 5'd0, 5'd22, mips_pkg::F_JALR);
		prog[39] = enc_i(mips_pkg::OP_ADDI, 5'd0, 5'd23, 16'd10);
		prog[40] = enc_j(mips_pkg::OP_J, 26'd40);	// Park here
		prog[42] = enc_i(mips_pkg::OP_ADDI, 5'd0, 5'd24, 16'd11);	// JAL target
		prog[43] = enc_r(5'd31, 5'd0, 5'd0, mips_pkg::F_JR);
		prog[44] = enc_i(mips_pkg::OP_ADDI, 5'd0, 5'd25, 16'd12);	// JALR target
		prog[45] = enc_r(5'd22, 5'd0, 5'd0, mips_pkg::F_JR);
	endtask

	task automatic print_counts;
		$display("errors: %0d, write events checked: %0d of %0d", err_count, seen_count, exp_count);
	endtask

	initial
	begin
		run        = 1'b0;
		imem_we    = 1'b0;
		imem_addr  = '0;
		imem_wdata = 32'h0;
		build_program();
		wait (rst_n);
		for (int i = 0; i < PROG_LEN; i++)
		begin
			@(posedge clk);
			imem_we    <= 1'b1;	// Load only while run is low
			imem_addr  <= PC_W'(i);
			imem_wdata <= prog[i];
		end
		@(posedge clk);
		imem_we <= 1'b0;
		@(posedge clk);
		run <= 1'b1;
		wait (all_seen);
		repeat (SETTLE) @(posedge clk);
		print_counts();
		if (err_count == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

	// Watchdog counted from the start of execution
	initial
	begin
		wait (run);
		#(WATCHDOG_T);
		$display("timeout: pc is %0d and never parked at %0d, %0d write events still missing",
			pc, FINAL_PC, exp_count - seen_count);
		print_counts();
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

//--- verification/result_checker.sv
module result_checker #(
	parameter int PC_W     = 8,
	parameter int FINAL_PC = 40	// Address of the closing jump-to-self
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic [PC_W-1:0]      pc,
	input  mips_pkg::wb_event_t  reg_wb,
	input  mips_pkg::mem_event_t mem_wr,
	output int                   err_count,
	output int                   seen_count,	// Write events consumed so far
	output int                   exp_count,
	output logic                 all_seen	// Every event seen and pc parked
);

	typedef struct packed {
		logic        is_mem;	// 0 register write, 1 memory write
		logic [7:0]  addr;
		logic [31:0] data;
	} exp_event_t;

	exp_event_t exp_q[$];

	function automatic exp_event_t reg_ev(input logic [4:0] addr, input logic [31:0] data);
		return '{is_mem: 1'b0, addr: {3'b0, addr}, data: data};
	endfunction

	function automatic exp_event_t mem_ev(input logic [7:0] addr, input logic [31:0] data);
		return '{is_mem: 1'b1, addr: addr, data: data};
	endfunction

	initial
	begin
		err_count  = 0;
		seen_count = 0;
		all_seen   = 1'b0;
		// R-type on 12 and -5
		exp_q.push_back(reg_ev(5'd1, 32'h0000000C));
		exp_q.push_back(reg_ev(5'd2, 32'hFFFFFFFB));	// ADDI sign-extends
		exp_q.push_back(reg_ev(5'd3, 32'h00000007));
		exp_q.push_back(reg_ev(5'd4, 32'h00000011));
		exp_q.push_back(reg_ev(5'd5, 32'h00000008));
		exp_q.push_back(reg_ev(5'd6, 32'hFFFFFFFF));
		exp_q.push_back(reg_ev(5'd7, 32'hFFFFFFF7));
		exp_q.push_back(reg_ev(5'd8, 32'h00000001));	// -5 < 12 signed
		exp_q.push_back(reg_ev(5'd9, 32'h00000000));
		// Immediates
		exp_q.push_back(reg_ev(5'd10, 32'h12340000));
		exp_q.push_back(reg_ev(5'd10, 32'h12348001));	// ORI zero-extends
		exp_q.push_back(reg_ev(5'd11, 32'h000080F0));
		exp_q.push_back(reg_ev(5'd12, 32'hFFFF0004));
		// Store then load back
		exp_q.push_back(mem_ev(8'h0F, 32'h12348001));
		exp_q.push_back(reg_ev(5'd13, 32'h12348001));
		exp_q.push_back(reg_ev(5'd14, 32'h0000000C));	// r0 read as zero
		// Branches, skipped writes leave gaps
		exp_q.push_back(reg_ev(5'd15, 32'h00000002));
		exp_q.push_back(reg_ev(5'd16, 32'h00000004));
		exp_q.push_back(reg_ev(5'd17, 32'h00000005));
		exp_q.push_back(reg_ev(5'd31, 32'h0000001E));	// BGEZAL taken links 30
		exp_q.push_back(reg_ev(5'd31, 32'h00000020));	// Not taken still links 32
		exp_q.push_back(reg_ev(5'd18, 32'h00000007));
		// Jumps and calls
		exp_q.push_back(reg_ev(5'd31, 32'h00000024));	// JAL at 35
		exp_q.push_back(reg_ev(5'd24, 32'h0000000B));
		exp_q.push_back(reg_ev(5'd20, 32'h00000009));	// After JR r31
		exp_q.push_back(reg_ev(5'd21, 32'h0000002C));
		exp_q.push_back(reg_ev(5'd22, 32'h00000027));	// JALR at 38
		exp_q.push_back(reg_ev(5'd25, 32'h0000000C));
		exp_q.push_back(reg_ev(5'd23, 32'h0000000A));	// After JR r22
		exp_count = exp_q.size();
	end

	task automatic check_event(input logic is_mem, input logic [7:0] addr,
		input logic [31:0] data, input string name);
		exp_event_t e;
		if (seen_count >= exp_count)
		begin
			err_count++;
			$display("unexpected %s write at %0t: addr %0h data %08h after the last expected event",
				name, $time, addr, data);
		end
		else
		begin
			e = exp_q[seen_count];
			if (e.is_mem != is_mem)
			begin
				err_count++;	// Wrong kind, an event went missing or was added
				$display("at %0t event %0d came as a %s write, expected the other kind",
					$time, seen_count, name);
			end
			else
			begin
				if (e.addr != addr)
				begin
					err_count++;
					$display("mismatch at %0t: %s.addr expected %0h actual %0h",
						$time, name, e.addr, addr);
				end
				if (e.data != data)
				begin
					err_count++;
					$display("mismatch at %0t: %s.data expected %08h actual %08h",
						$time, name, e.data, data);
				end
			end
			seen_count++;
		end
	endtask

	// Outputs are settled before the edge, state moves only after it
	always @(posedge clk)
	begin
		if (rst_n)
		begin
			if (reg_wb.valid)
				check_event(1'b0, {3'b0, reg_wb.addr}, reg_wb.data, "reg_wb");
			if (mem_wr.valid)
				check_event(1'b1, mem_wr.addr, mem_wr.data, "mem_wr");
			if (all_seen && pc != FINAL_PC[PC_W-1:0])
			begin
				err_count++;	// Core left the closing loop
				$display("mismatch at %0t: pc expected %0d actual %0d", $time, FINAL_PC, pc);
			end
			if (!all_seen && seen_count == exp_count && pc == FINAL_PC[PC_W-1:0])
				all_seen <= 1'b1;
		end
	end

endmodule

//--- verification/clock_gen.sv
module clock_gen #(
	parameter int HALF_PERIOD  = 2,	// Period 4
	parameter int RESET_CYCLES = 8	// Rising edges with rst_n low
) (
	output logic clk,
	output logic rst_n
);

	initial
	begin
		clk   = 1'b0;
		rst_n = 1'b0;	// Reset from time 0
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;	// Released on an edge, DUT reset is synchronous
	end

	always #(HALF_PERIOD) clk = ~clk;

endmodule

//--- hdl/mips_core.sv
module mips_core #(
	parameter int PC_W    = 8,	// Instruction address width
	parameter int DMEM_AW = mips_pkg::DMEM_AW_DEF	// Data address width
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 run,	// Level, core executes while high
	input  logic                 imem_we,	// Program load strobe
	input  logic [PC_W-1:0]      imem_addr,
	input  logic [31:0]          imem_wdata,
	output logic [PC_W-1:0]      pc,
	output mips_pkg::wb_event_t  reg_wb,	// Register write of this cycle
	output mips_pkg::mem_event_t mem_wr	// Memory write of this cycle
);

	logic [31:0]          instr;
	mips_pkg::ctrl_t      ctrl;
	mips_pkg::alu_fn_t    alu_fn;
	mips_pkg::opcode_t    opcode;
	mips_pkg::funct_t     funct;
	logic [4:0]           rs, rt, rd;
	logic [15:0]          imm;
	logic [31:0]          imm_ext;	// Per imm_signed
	logic [31:0]          imm_sext;	// Always signed, branch offset
	logic [31:0]          rs_data, rt_data;
	logic [31:0]          alu_b, alu_result;
	logic                 alu_zero, alu_neg;
	logic [31:0]          dmem_rdata;
	logic [PC_W-1:0]      pc_plus1, branch_target, next_pc;
	logic                 branch_taken;
	logic [4:0]           wb_addr;
	logic [31:0]          wb_data;
	logic [31:0]          ret_addr;	// pc+1 zero-extended

	// Field split
	assign opcode = mips_pkg::opcode_t'(instr[31:26]);
	assign funct  = mips_pkg::funct_t'(instr[5:0]);
	assign rs     = instr[25:21];
	assign rt     = instr[20:16];
	assign rd     = instr[15:11];
	assign imm    = instr[15:0];

	assign imm_sext = {{16{imm[15]}}, imm};
	assign imm_ext  = ctrl.imm_signed ? imm_sext : {16'b0, imm};
	assign alu_b    = ctrl.alu_src_imm ? imm_ext : rt_data;

	assign pc_plus1      = pc + 1'b1;
	assign branch_target = pc_plus1 + imm_sext[PC_W-1:0];	// Word offset
	assign ret_addr      = {{(32-PC_W){1'b0}}, pc_plus1};

	// BGEZ checks sign of rs, BEQ/BNE check zero of rs - rt
	assign branch_taken = (ctrl.alu_class == mips_pkg::AC_GEZ) ? !alu_neg :
		(ctrl.branch_eq ? alu_zero : !alu_zero);

	always_comb
	begin
		case (ctrl.pc_src)
			mips_pkg::PC_BRANCH: next_pc = branch_taken ? branch_target : pc_plus1;
			mips_pkg::PC_JUMP:   next_pc = instr[PC_W-1:0];	// Low bits of 26-bit target
			mips_pkg::PC_REG:    next_pc = rs_data[PC_W-1:0];
			default:             next_pc = pc_plus1;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			pc <= '0;
		end
		else if (run)
		begin
			pc <= next_pc;	// Holds while loading
		end
	end

	always_comb
	begin
		case (ctrl.reg_dst)
			mips_pkg::DST_RD: wb_addr = rd;
			mips_pkg::DST_RA: wb_addr = 5'd31;
			default:          wb_addr = rt;
		endcase
		case (ctrl.wb_src)
			mips_pkg::WB_MEM: wb_data = dmem_rdata;
			mips_pkg::WB_RET: wb_data = ret_addr;
			default:          wb_data = alu_result;
		endcase
	end

	// Writes to $zero never show up as events
	assign reg_wb.valid = ctrl.reg_we && run && (wb_addr != 5'd0);
	assign reg_wb.addr  = wb_addr;
	assign reg_wb.data  = wb_data;

	assign mem_wr.valid = ctrl.mem_we && run;
	assign mem_wr.addr  = alu_result[DMEM_AW-1:0];	// Address modulo depth
	assign mem_wr.data  = rt_data;

	instr_memory #(.PC_W(PC_W)) u_imem (
		.clk   (clk),
		.we    (imem_we),
		.waddr (imem_addr),
		.wdata (imem_wdata),
		.raddr (pc),
		.rdata (instr)
	);

	control_unit u_ctrl (
		.opcode (opcode),
		.funct  (funct),
		.rt     (rt),
		.ctrl   (ctrl)
	);

	alu_control u_alu_ctrl (
		.alu_class (ctrl.alu_class),
		.funct     (funct),
		.alu_fn    (alu_fn)
	);

	register_file u_regs (
		.clk     (clk),
		.rst_n   (rst_n),
		.rs_addr (rs),
		.rt_addr (rt),
		.rs_data (rs_data),
		.rt_data (rt_data),
		.wb      (reg_wb)
	);

	alu u_alu (
		.alu_fn (alu_fn),
		.a      (rs_data),
		.b      (alu_b),
		.result (alu_result),
		.zero   (alu_zero),
		.neg    (alu_neg)
	);

	data_memory #(.DMEM_AW(DMEM_AW)) u_dmem (
		.clk   (clk),
		.rst_n (rst_n),
		.wr    (mem_wr),
		.raddr (alu_result[DMEM_AW-1:0]),
		.rdata (dmem_rdata)
	);

endmodule

//--- hdl/data_memory.sv
module data_memory #(
	parameter int DMEM_AW = 8	// Word address width
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  mips_pkg::mem_event_t wr,	// Store event from core
	input  logic [DMEM_AW-1:0]   raddr,	// Same ALU address as wr.addr
	output logic [31:0]          rdata
);

	logic [31:0] mem [2**DMEM_AW];	// Word-addressed data store

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < 2**DMEM_AW; i++)
			begin
				mem[i] <= 32'd0;	// Start from a known image
			end
		end
		else if (wr.valid)
		begin
			mem[wr.addr] <= wr.data;
		end
	end

	assign rdata = mem[raddr];	// LW data within the cycle

endmodule

//--- hdl/instr_memory.sv
module instr_memory #(
	parameter int PC_W = 8	// Word address width
) (
	input  logic            clk,
	input  logic            we,	// Load strobe from testbench
	input  logic [PC_W-1:0] waddr,
	input  logic [31:0]     wdata,
	input  logic [PC_W-1:0] raddr,	// Current PC
	output logic [31:0]     rdata	// Instruction word
);

	logic [31:0] mem [2**PC_W];	// Program store, no reset

	always_ff @(posedge clk)
	begin
		if (we)
		begin
			mem[waddr] <= wdata;
		end
	end

	assign rdata = mem[raddr];	// Fetch in same cycle

endmodule

//--- hdl/register_file.sv
module register_file (
	input  logic               clk,
	input  logic               rst_n,
	input  logic [4:0]         rs_addr,	// Read port A
	input  logic [4:0]         rt_addr,	// Read port B
	output logic [31:0]        rs_data,
	output logic [31:0]        rt_data,
	input  mips_pkg::wb_event_t wb	// Write port, already gated by run
);

	logic [31:0] regs [32];	// General purpose registers

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < 32; i++)
			begin
				regs[i] <= 32'd0;	// Clear whole file
			end
		end
		else if (wb.valid)
		begin
			regs[wb.addr] <= wb.data;
		end
	end

	// $zero always reads as zero whatever was stored
	assign rs_data = (rs_addr == 5'd0) ? 32'd0 : regs[rs_addr];
	assign rt_data = (rt_addr == 5'd0) ? 32'd0 : regs[rt_addr];

endmodule

//--- hdl/alu.sv
module alu (
	input  mips_pkg::alu_fn_t alu_fn,	// Operation select
	input  logic [31:0]       a,	// rs
	input  logic [31:0]       b,	// rt or extended immediate
	output logic [31:0]       result,
	output logic              zero,	// Result is all zeros
	output logic              neg	// Result sign bit
);

	logic lt_signed;	// Signed a < b

	assign lt_signed = ($signed(a) < $signed(b));

	always_comb
	begin
		case (alu_fn)
			mips_pkg::FN_ADD:    result = a + b;
			mips_pkg::FN_SUB:    result = a - b;
			mips_pkg::FN_AND:    result = a & b;
			mips_pkg::FN_OR:     result = a | b;
			mips_pkg::FN_XOR:    result = a ^ b;
			mips_pkg::FN_SLT:    result = {31'b0, lt_signed};
			mips_pkg::FN_LUI:    result = {b[15:0], 16'b0};	// Immediate to upper half
			mips_pkg::FN_PASS_A: result = a;
			default:             result = a + b;
		endcase
	end

	// Branch flags, BEQ/BNE on sub and BGEZ on pass_a
	assign zero = (result == 32'd0);
	assign neg  = result[31];

endmodule

//--- hdl/alu_control.sv
module alu_control (
	input  mips_pkg::alu_class_t alu_class,	// Request from decoder
	input  mips_pkg::funct_t     funct,	// Used for the funct class only
	output mips_pkg::alu_fn_t    alu_fn	// Concrete ALU operation
);

	always_comb
	begin
		case (alu_class)
			mips_pkg::AC_ADD:   alu_fn = mips_pkg::FN_ADD;
			mips_pkg::AC_SUB:   alu_fn = mips_pkg::FN_SUB;
			mips_pkg::AC_AND:   alu_fn = mips_pkg::FN_AND;
			mips_pkg::AC_OR:    alu_fn = mips_pkg::FN_OR;
			mips_pkg::AC_XOR:   alu_fn = mips_pkg::FN_XOR;
			mips_pkg::AC_LUI:   alu_fn = mips_pkg::FN_LUI;
			mips_pkg::AC_GEZ:   alu_fn = mips_pkg::FN_PASS_A;	// Core reads sign of rs
			mips_pkg::AC_FUNCT:
			begin
				case (funct)
					mips_pkg::F_ADD, mips_pkg::F_ADDU: alu_fn = mips_pkg::FN_ADD;	// No overflow trap
					mips_pkg::F_SUB, mips_pkg::F_SUBU: alu_fn = mips_pkg::FN_SUB;
					mips_pkg::F_AND:                   alu_fn = mips_pkg::FN_AND;
					mips_pkg::F_OR:                    alu_fn = mips_pkg::FN_OR;
					mips_pkg::F_XOR:                   alu_fn = mips_pkg::FN_XOR;
					mips_pkg::F_SLT:                   alu_fn = mips_pkg::FN_SLT;
					default:                           alu_fn = mips_pkg::FN_ADD;
				endcase
			end
			default:            alu_fn = mips_pkg::FN_ADD;
		endcase
	end

endmodule

//--- hdl/control_unit.sv
module control_unit (
	input  mips_pkg::opcode_t opcode,	// Major opcode
	input  mips_pkg::funct_t  funct,	// R-type function
	input  logic [4:0]        rt,	// Selects BGEZ or BGEZAL
	output mips_pkg::ctrl_t   ctrl	// Datapath selects
);

	always_comb
	begin
		// Safe defaults, increment with nothing written
		ctrl.pc_src      = mips_pkg::PC_INC;
		ctrl.reg_dst     = mips_pkg::DST_RT;
		ctrl.wb_src      = mips_pkg::WB_ALU;
		ctrl.alu_class   = mips_pkg::AC_ADD;
		ctrl.mem_we      = 1'b0;
		ctrl.alu_src_imm = 1'b0;
		ctrl.reg_we      = 1'b0;
		ctrl.branch_eq   = 1'b1;
		ctrl.imm_signed  = 1'b1;

		case (opcode)
			mips_pkg::OP_RTYPE:
			begin
				case (funct)
					mips_pkg::F_ADD, mips_pkg::F_ADDU, mips_pkg::F_SUB, mips_pkg::F_SUBU,
					mips_pkg::F_AND, mips_pkg::F_OR, mips_pkg::F_XOR, mips_pkg::F_SLT:
					begin
						ctrl.reg_dst   = mips_pkg::DST_RD;	// Three-register form
						ctrl.alu_class = mips_pkg::AC_FUNCT;	// ALU control reads funct
						ctrl.reg_we    = 1'b1;
					end
					mips_pkg::F_JR:
					begin
						ctrl.pc_src = mips_pkg::PC_REG;	// PC = rs
					end
					mips_pkg::F_JALR:
					begin
						ctrl.pc_src  = mips_pkg::PC_REG;	// PC = rs
						ctrl.reg_dst = mips_pkg::DST_RD;	// Link goes to rd
						ctrl.wb_src  = mips_pkg::WB_RET;	// Store pc+1
						ctrl.reg_we  = 1'b1;
					end
					default:
					begin
						ctrl.reg_we = 1'b0;	// Shifts and multiply moves, no-op
					end
				endcase
			end
			mips_pkg::OP_MUL:
			begin
				ctrl.reg_we = 1'b0;	// No multiply unit, no writes at all
				ctrl.mem_we = 1'b0;
			end
			mips_pkg::OP_ADDI, mips_pkg::OP_ADDIU:
			begin
				ctrl.alu_src_imm = 1'b1;	// Sign-extended immediate
				ctrl.reg_we      = 1'b1;
			end
			mips_pkg::OP_ANDI:
			begin
				ctrl.alu_class   = mips_pkg::AC_AND;
				ctrl.alu_src_imm = 1'b1;
				ctrl.reg_we      = 1'b1;
				ctrl.imm_signed  = 1'b0;	// Logical immediates zero-extend
			end
			mips_pkg::OP_ORI:
			begin
				ctrl.alu_class   = mips_pkg::AC_OR;
				ctrl.alu_src_imm = 1'b1;
				ctrl.reg_we      = 1'b1;
				ctrl.imm_signed  = 1'b0;
			end
			mips_pkg::OP_XORI:
			begin
				ctrl.alu_class   = mips_pkg::AC_XOR;
				ctrl.alu_src_imm = 1'b1;
				ctrl.reg_we      = 1'b1;
				ctrl.imm_signed  = 1'b0;
			end
			mips_pkg::OP_LUI:
			begin
				ctrl.alu_class   = mips_pkg::AC_LUI;	// Immediate to upper half
				ctrl.alu_src_imm = 1'b1;
				ctrl.reg_we      = 1'b1;
				ctrl.imm_signed  = 1'b0;
			end
			mips_pkg::OP_LW:
			begin
				ctrl.wb_src      = mips_pkg::WB_MEM;	// Load data to rt
				ctrl.alu_src_imm = 1'b1;	// base + offset
				ctrl.reg_we      = 1'b1;
			end
			mips_pkg::OP_SW:
			begin
				ctrl.alu_src_imm = 1'b1;	// base + offset
				ctrl.mem_we      = 1'b1;
			end
			mips_pkg::OP_BEQ, mips_pkg::OP_BNE:
			begin
				ctrl.pc_src    = mips_pkg::PC_BRANCH;
				ctrl.alu_class = mips_pkg::AC_SUB;	// rs - rt, look at zero
				ctrl.branch_eq = (opcode == mips_pkg::OP_BEQ);
			end
			mips_pkg::OP_REGIMM:
			begin
				if (rt == mips_pkg::RT_BGEZ || rt == mips_pkg::RT_BGEZAL)
				begin
					ctrl.pc_src      = mips_pkg::PC_BRANCH;
					ctrl.alu_class   = mips_pkg::AC_GEZ;	// Pass rs for sign test
					ctrl.alu_src_imm = 1'b1;
					ctrl.reg_dst     = mips_pkg::DST_RA;
					ctrl.wb_src      = mips_pkg::WB_RET;
					ctrl.reg_we      = (rt == mips_pkg::RT_BGEZAL);	// Link only for AL
				end
			end
			mips_pkg::OP_J:
			begin
				ctrl.pc_src = mips_pkg::PC_JUMP;
			end
			mips_pkg::OP_JAL:
			begin
				ctrl.pc_src  = mips_pkg::PC_JUMP;
				ctrl.reg_dst = mips_pkg::DST_RA;	// $ra = pc+1
				ctrl.wb_src  = mips_pkg::WB_RET;
				ctrl.reg_we  = 1'b1;
			end
			default:
			begin
				ctrl.pc_src = mips_pkg::PC_INC;	// Unknown opcode, plain no-op
			end
		endcase
	end

endmodule

//--- hdl/mips_pkg.sv
package mips_pkg;

	// Address width of the memory write event, default for the core
	localparam int DMEM_AW_DEF = 8;

	// REGIMM branch selectors carried in the rt field
	localparam logic [4:0] RT_BGEZ   = 5'b00001;
	localparam logic [4:0] RT_BGEZAL = 5'b10001;

	typedef enum logic [5:0] {
		OP_RTYPE  = 6'b000000,	// Look at funct
		OP_REGIMM = 6'b000001,	// BGEZ, BGEZAL by rt
		OP_J      = 6'b000010,
		OP_JAL    = 6'b000011,
		OP_BEQ    = 6'b000100,
		OP_BNE    = 6'b000101,
		OP_ADDI   = 6'b001000,
		OP_ADDIU  = 6'b001001,
		OP_ANDI   = 6'b001100,
		OP_ORI    = 6'b001101,
		OP_XORI   = 6'b001110,
		OP_LUI    = 6'b001111,
		OP_MUL    = 6'b011100,	// Multiply group, not implemented
		OP_LW     = 6'b100011,
		OP_SW     = 6'b101011
	} opcode_t;

	typedef enum logic [5:0] {
		F_JR   = 6'b001000,
		F_JALR = 6'b001001,
		F_ADD  = 6'b100000,
		F_ADDU = 6'b100001,
		F_SUB  = 6'b100010,
		F_SUBU = 6'b100011,
		F_AND  = 6'b100100,
		F_OR   = 6'b100101,
		F_XOR  = 6'b100110,
		F_SLT  = 6'b101010
	} funct_t;

	// ALU request from the decoder, same codes as the old opALU field
	typedef enum logic [3:0] {
		AC_ADD   = 4'b0000,
		AC_SUB   = 4'b0001,
		AC_AND   = 4'b0010,
		AC_OR    = 4'b0100,
		AC_XOR   = 4'b0101,
		AC_FUNCT = 4'b0110,	// R-type, resolved from funct
		AC_GEZ   = 4'b0111,	// Sign test of rs
		AC_LUI   = 4'b1001
	} alu_class_t;

	// Operation the ALU really performs
	typedef enum logic [3:0] {
		FN_ADD    = 4'd0,
		FN_SUB    = 4'd1,
		FN_AND    = 4'd2,
		FN_OR     = 4'd3,
		FN_XOR    = 4'd4,
		FN_SLT    = 4'd5,
		FN_LUI    = 4'd6,
		FN_PASS_A = 4'd7
	} alu_fn_t;

	typedef enum logic [1:0] {
		PC_BRANCH = 2'b00,
		PC_JUMP   = 2'b01,
		PC_REG    = 2'b10,
		PC_INC    = 2'b11
	} pc_src_t;

	typedef enum logic [1:0] {
		DST_RT = 2'd0,
		DST_RD = 2'd1,
		DST_RA = 2'd2	// Register 31
	} reg_dst_t;

	typedef enum logic [1:0] {
		WB_ALU = 2'b00,
		WB_MEM = 2'b01,
		WB_RET = 2'b10	// pc+1
	} wb_src_t;

	typedef struct packed {
		pc_src_t    pc_src;
		reg_dst_t   reg_dst;
		wb_src_t    wb_src;
		alu_class_t alu_class;
		logic       mem_we;
		logic       alu_src_imm;	// Operand b from immediate
		logic       reg_we;
		logic       branch_eq;	// 1 for BEQ, 0 for BNE
		logic       imm_signed;
	} ctrl_t;

	typedef struct packed {
		logic        valid;
		logic [4:0]  addr;
		logic [31:0] data;
	} wb_event_t;

	typedef struct packed {
		logic                   valid;
		logic [DMEM_AW_DEF-1:0] addr;
		logic [31:0]            data;
	} mem_event_t;

endpackage
